/* logic/memTypesPkg.sv */
package memTypesPkg;

    // width of one RAM word and of a byte address
    localparam int wordWidth = 32;
    localparam int addrWidth = 32;

    // address bit that picks the word inside a two-word block
    localparam int wordSelBit = 2;

    typedef logic [wordWidth-1:0] wordT;
    typedef logic [addrWidth-1:0] addrT;

    // RAM status as seen by the controller
    // FREE    idle, nothing requested
    // BUSY    access in progress
    // ACCESS  word completes this cycle
    // ERROR   reported by the RAM itself
    typedef enum logic [1:0] {
        FREE,
        BUSY,
        ACCESS,
        ERROR
    } ramStateT;

endpackage

/* logic/coherencePkg.sv */
package coherencePkg;

    // arbitration is written for exactly two cores
    localparam int coreCount = 2;

    typedef logic coreIdxT;

    // transaction states of the bus controller
    typedef enum logic [2:0] {
        IDLE,
        IFETCH,
        SNOOP,
        SNOOPWB,
        MEMRD,
        WB
    } busStateT;

    // kind of request held by the grant
    typedef enum logic [1:0] {
        NONE,
        IREAD,
        DREAD,
        DWRITE
    } reqKindT;

    // with two cores the snooped cache is simply the other one
    function automatic coreIdxT otherCore(coreIdxT core);
        return ~core;
    endfunction

endpackage

/* logic/requestArbiter.sv */
`timescale 1ns/1ns

module requestArbiter (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic [coherencePkg::coreCount-1:0] iREN,
    input  logic [coherencePkg::coreCount-1:0] dREN,
    input  logic [coherencePkg::coreCount-1:0] dWEN,
    input  coherencePkg::busStateT            busState,
    input  logic                              releaseGrant,
    output logic                              grantValid,
    output coherencePkg::coreIdxT             grantCore,
    output coherencePkg::reqKindT             grantKind
);
    import coherencePkg::*;

    logic    pickValid;
    coreIdxT pickCore;
    reqKindT pickKind;
    logic    justReleased;
    logic    canGrant;

    // later matches override earlier ones, so data beats instruction
    // and core 0 beats core 1
    always_comb begin
        pickCore = '0;
        pickKind = NONE;
        for (int c = coreCount - 1; c >= 0; c--) begin
            if (iREN[c]) begin
                pickCore = coreIdxT'(c);
                pickKind = IREAD;
            end
        end
        for (int c = coreCount - 1; c >= 0; c--) begin
            if (dREN[c] || dWEN[c]) begin
                pickCore = coreIdxT'(c);
                pickKind = dREN[c] ? DREAD : DWRITE;
            end
        end
        pickValid = (pickKind != NONE);
    end

    // skip the cycle after a release, the finished core may still hold its request
    assign canGrant = (busState == IDLE) && !grantValid && !justReleased && pickValid;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            grantValid   <= 1'b0;
            grantCore    <= '0;
            grantKind    <= NONE;
            justReleased <= 1'b0;
        end else begin
            justReleased <= releaseGrant;
            if (releaseGrant) begin
                grantValid <= 1'b0;
                grantKind  <= NONE;
            end else if (canGrant) begin
                grantValid <= 1'b1;
                grantCore  <= pickCore;
                grantKind  <= pickKind;
            end
        end
    end

endmodule

/* logic/coherenceFsm.sv */
`timescale 1ns/1ns

module coherenceFsm (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic                              grantValid,
    input  coherencePkg::coreIdxT             grantCore,
    input  coherencePkg::reqKindT             grantKind,
    input  logic [coherencePkg::coreCount-1:0] cctrans,
    input  logic [coherencePkg::coreCount-1:0] ccwrite,
    input  logic                              wordDone,
    output coherencePkg::busStateT            busState,
    output logic                              wordIdx,
    output logic                              dirtyHit,
    output logic                              releaseGrant
);
    import coherencePkg::*;

    busStateT nextState;
    logic     nextWordIdx;
    logic     nextDirtyHit;
    coreIdxT  snoopCore;
    logic     lastWord;

    assign snoopCore = otherCore(grantCore);
    assign lastWord  = wordDone && wordIdx;

    always_comb begin
        nextState    = busState;
        nextWordIdx  = wordIdx;
        nextDirtyHit = dirtyHit;
        releaseGrant = 1'b0;

        unique case (busState)
            IDLE: begin
                nextWordIdx = 1'b0;
                if (grantValid) begin
                    unique case (grantKind)
                        IREAD: begin
                            nextState = IFETCH;
                        end
                        DREAD: begin
                            nextState    = SNOOP;
                            nextDirtyHit = 1'b0;
                        end
                        DWRITE: begin
                            nextState = WB;
                        end
                        default: begin
                            nextState = IDLE;
                        end
                    endcase
                end
            end

            // single word, done as soon as the RAM answers
            IFETCH: begin
                if (wordDone) begin
                    nextState    = IDLE;
                    releaseGrant = 1'b1;
                end
            end

            // no timeout, the other cache always answers eventually
            SNOOP: begin
                if (cctrans[snoopCore]) begin
                    nextDirtyHit = ccwrite[snoopCore];
                    nextState    = ccwrite[snoopCore] ? SNOOPWB : MEMRD;
                end
            end

            // owner flushes both words, then the requester reads them back
            SNOOPWB: begin
                if (wordDone) begin
                    nextWordIdx = !wordIdx;
                    if (lastWord) begin
                        nextState = MEMRD;
                    end
                end
            end

            MEMRD, WB: begin
                if (wordDone) begin
                    nextWordIdx = !wordIdx;
                    if (lastWord) begin
                        nextState    = IDLE;
                        releaseGrant = 1'b1;
                    end
                end
            end

            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busState <= IDLE;
            wordIdx  <= 1'b0;
            dirtyHit <= 1'b0;
        end else begin
            busState <= nextState;
            wordIdx  <= nextWordIdx;
            dirtyHit <= nextDirtyHit;
        end
    end

endmodule

/* logic/busDatapath.sv */
`timescale 1ns/1ns

module busDatapath (
    input  coherencePkg::coreIdxT                               grantCore,
    input  coherencePkg::reqKindT                               grantKind,
    input  coherencePkg::busStateT                              busState,
    input  logic                                                wordIdx,
    input  logic                                                dirtyHit,
    input  logic [coherencePkg::coreCount-1:0]                  iREN,
    input  logic [coherencePkg::coreCount-1:0]                  dREN,
    input  logic [coherencePkg::coreCount-1:0]                  dWEN,
    input  logic [coherencePkg::coreCount-1:0]                  ccwrite,
    input  logic [coherencePkg::coreCount-1:0]                  cctrans,
    input  memTypesPkg::addrT [coherencePkg::coreCount-1:0]     iaddr,
    input  memTypesPkg::addrT [coherencePkg::coreCount-1:0]     daddr,
    input  memTypesPkg::wordT [coherencePkg::coreCount-1:0]     dstore,
    input  memTypesPkg::wordT                                   ramload,
    input  memTypesPkg::ramStateT                               ramstate,
    output logic                                                ramREN,
    output logic                                                ramWEN,
    output memTypesPkg::addrT                                   ramaddr,
    output memTypesPkg::wordT                                   ramstore,
    output memTypesPkg::wordT [coherencePkg::coreCount-1:0]     iload,
    output memTypesPkg::wordT [coherencePkg::coreCount-1:0]     dload,
    output logic [coherencePkg::coreCount-1:0]                  iwait,
    output logic [coherencePkg::coreCount-1:0]                  dwait,
    output logic [coherencePkg::coreCount-1:0]                  ccwait,
    output logic [coherencePkg::coreCount-1:0]                  ccinv,
    output memTypesPkg::addrT [coherencePkg::coreCount-1:0]     ccsnoopaddr,
    output logic                                                wordDone
);
    import memTypesPkg::*;
    import coherencePkg::*;

    coreIdxT snoopCore;
    addrT    wordAddr;
    logic    snoopBusy;

    assign snoopCore = otherCore(grantCore);

    assign ramREN   = (busState == IFETCH) || (busState == MEMRD);
    assign ramWEN   = (busState == SNOOPWB) || (busState == WB);
    assign wordDone = (ramREN || ramWEN) && (ramstate == ACCESS);

    // second word of the block sits at the flipped word-select bit
    always_comb begin
        wordAddr             = daddr[grantCore];
        wordAddr[wordSelBit] = daddr[grantCore][wordSelBit] ^ wordIdx;
    end

    assign ramaddr = (grantKind == IREAD) ? iaddr[grantCore] : wordAddr;

    // dirty data comes from the owner during the snoop writeback
    assign ramstore = (busState == SNOOPWB) ? dstore[snoopCore] : dstore[grantCore];

    // owner stays parked until the requester has its copy of a dirty block
    assign snoopBusy = (busState == SNOOP) || (busState == SNOOPWB)
                    || ((busState == MEMRD) && dirtyHit);

    always_comb begin
        for (int c = 0; c < coreCount; c++) begin
            iload[c]       = '0;
            dload[c]       = '0;
            iwait[c]       = 1'b1;
            dwait[c]       = 1'b1;
            ccwait[c]      = 1'b0;
            ccinv[c]       = 1'b0;
            ccsnoopaddr[c] = '0;
            if (coreIdxT'(c) == grantCore) begin
                iwait[c] = !((busState == IFETCH) && iREN[c] && wordDone);
                dwait[c] = !(((busState == MEMRD) || (busState == WB))
                             && (dREN[c] || dWEN[c]) && wordDone);
                if (busState == IFETCH) begin
                    iload[c] = ramload;
                end
                if (busState == MEMRD) begin
                    dload[c] = ramload;
                end
            end else begin
                ccwait[c] = snoopBusy;
                // write intent on the requester side means ownership, drop the copy
                ccinv[c]  = (busState == SNOOP) && cctrans[c] && ccwrite[grantCore];
                if (snoopBusy) begin
                    ccsnoopaddr[c] = wordAddr;
                end
            end
        end
    end

endmodule

/* logic/busController.sv */
`timescale 1ns/1ns

module busController (
    input  logic                                            CLK,
    input  logic                                            nRST,
    input  logic [coherencePkg::coreCount-1:0]              iREN,
    input  logic [coherencePkg::coreCount-1:0]              dREN,
    input  logic [coherencePkg::coreCount-1:0]              dWEN,
    input  logic [coherencePkg::coreCount-1:0]              ccwrite,
    input  logic [coherencePkg::coreCount-1:0]              cctrans,
    input  memTypesPkg::addrT [coherencePkg::coreCount-1:0] iaddr,
    input  memTypesPkg::addrT [coherencePkg::coreCount-1:0] daddr,
    input  memTypesPkg::wordT [coherencePkg::coreCount-1:0] dstore,
    output memTypesPkg::wordT [coherencePkg::coreCount-1:0] iload,
    output memTypesPkg::wordT [coherencePkg::coreCount-1:0] dload,
    output logic [coherencePkg::coreCount-1:0]              iwait,
    output logic [coherencePkg::coreCount-1:0]              dwait,
    output logic [coherencePkg::coreCount-1:0]              ccwait,
    output logic [coherencePkg::coreCount-1:0]              ccinv,
    output memTypesPkg::addrT [coherencePkg::coreCount-1:0] ccsnoopaddr,
    output logic                                            ramREN,
    output logic                                            ramWEN,
    output memTypesPkg::addrT                               ramaddr,
    output memTypesPkg::wordT                               ramstore,
    input  memTypesPkg::wordT                               ramload,
    input  memTypesPkg::ramStateT                           ramstate
);
    import coherencePkg::*;

    // grant held for the whole transaction
    logic     grantValid;
    coreIdxT  grantCore;
    reqKindT  grantKind;

    busStateT busState;
    logic     wordIdx;
    logic     dirtyHit;
    logic     releaseGrant;
    logic     wordDone;

    requestArbiter i_requestArbiter (
        .CLK          (CLK),
        .nRST         (nRST),
        .iREN         (iREN),
        .dREN         (dREN),
        .dWEN         (dWEN),
        .busState     (busState),
        .releaseGrant (releaseGrant),
        .grantValid   (grantValid),
        .grantCore    (grantCore),
        .grantKind    (grantKind)
    );

    coherenceFsm i_coherenceFsm (
        .CLK          (CLK),
        .nRST         (nRST),
        .grantValid   (grantValid),
        .grantCore    (grantCore),
        .grantKind    (grantKind),
        .cctrans      (cctrans),
        .ccwrite      (ccwrite),
        .wordDone     (wordDone),
        .busState     (busState),
        .wordIdx      (wordIdx),
        .dirtyHit     (dirtyHit),
        .releaseGrant (releaseGrant)
    );

    busDatapath i_busDatapath (
        .grantCore   (grantCore),
        .grantKind   (grantKind),
        .busState    (busState),
        .wordIdx     (wordIdx),
        .dirtyHit    (dirtyHit),
        .iREN        (iREN),
        .dREN        (dREN),
        .dWEN        (dWEN),
        .ccwrite     (ccwrite),
        .cctrans     (cctrans),
        .iaddr       (iaddr),
        .daddr       (daddr),
        .dstore      (dstore),
        .ramload     (ramload),
        .ramstate    (ramstate),
        .ramREN      (ramREN),
        .ramWEN      (ramWEN),
        .ramaddr     (ramaddr),
        .ramstore    (ramstore),
        .iload       (iload),
        .dload       (dload),
        .iwait       (iwait),
        .dwait       (dwait),
        .ccwait      (ccwait),
        .ccinv       (ccinv),
        .ccsnoopaddr (ccsnoopaddr),
        .wordDone    (wordDone)
    );

endmodule

/* testbench/tbClock.sv */
`timescale 1ns/1ns

module tbClock (
    output logic CLK
);
    // 8 ns period
    initial begin
        CLK = 1'b0;
    end

    always #4 CLK = ~CLK;

endmodule

/* testbench/busController_assertions.sv */
`timescale 1ns/1ns

module busController_assertions (
    input logic                               CLK,
    input logic                               nRST,
    input logic                               ramREN,
    input logic                               ramWEN,
    input logic [coherencePkg::coreCount-1:0] ccwait,
    input logic [coherencePkg::coreCount-1:0] ccinv,
    input logic [coherencePkg::coreCount-1:0] dwait,
    input logic [coherencePkg::coreCount-1:0] dREN,
    input logic [coherencePkg::coreCount-1:0] dWEN
);
    import coherencePkg::*;

    noDoubleEnable: assert property (@(posedge CLK) disable iff (!nRST)
        !(ramREN && ramWEN))
        else $error("ramREN and ramWEN high together");

    // invalidate only reaches a cache that is being snooped
    invOnlyInSnoop: assert property (@(posedge CLK) disable iff (!nRST)
        (ccinv & ~ccwait) == '0)
        else $error("ccinv high without ccwait");

    dwaitNeedsRequest: assert property (@(posedge CLK) disable iff (!nRST)
        (~dwait & ~(dREN | dWEN)) == '0)
        else $error("dwait dropped without a data request");

    quietInReset: assert property (@(posedge CLK)
        !nRST |-> (!ramREN && !ramWEN && ccwait == '0 && ccinv == '0))
        else $error("bus outputs active during reset");

endmodule

/* testbench/busControllerTb.sv */
`timescale 1ns/1ns

module busControllerTb;
    import memTypesPkg::*;
    import coherencePkg::*;

    localparam int timeoutCycles = 200;

    logic                 CLK;
    logic                 nRST;
    logic [coreCount-1:0] iREN;
    logic [coreCount-1:0] dREN;
    logic [coreCount-1:0] dWEN;
    logic [coreCount-1:0] ccwrite;
    logic [coreCount-1:0] cctrans;
    addrT [coreCount-1:0] iaddr;
    addrT [coreCount-1:0] daddr;
    addrT [coreCount-1:0] ccsnoopaddr;
    wordT [coreCount-1:0] dstore;
    wordT [coreCount-1:0] iload;
    wordT [coreCount-1:0] dload;
    logic [coreCount-1:0] iwait;
    logic [coreCount-1:0] dwait;
    logic [coreCount-1:0] ccwait;
    logic [coreCount-1:0] ccinv;
    logic                 ramREN;
    logic                 ramWEN;
    addrT                 ramaddr;
    wordT                 ramstore;
    wordT                 ramload;
    ramStateT             ramstate;

    // cache side models
    logic [coreCount-1:0] intent;
    logic [coreCount-1:0] respTrans;
    logic [coreCount-1:0] respWrite;
    logic [coreCount-1:0] dirtyMode;
    logic [coreCount-1:0] answered;
    wordT [coreCount-1:0] storeData;
    wordT [coreCount-1:0] dirtyLo;
    wordT [coreCount-1:0] dirtyHi;
    int                   respDelay [coreCount];
    int                   invCount [coreCount];

    wordT        ramMem [addrT];
    wordT        shadow [addrT];
    logic [31:0] rngState;
    int          busyLeft;

    tbClock i_tbClock (.CLK(CLK));

    busController i_busController (.*);

    bind busController busController_assertions i_busControllerAssertions (.*);

    assign cctrans = respTrans;
    assign ccwrite = respWrite | intent;

    // snooped cache serves its dirty block instead of the writeback data
    always_comb begin
        for (int c = 0; c < coreCount; c++) begin
            dstore[c] = storeData[c];
            if (ccwait[c]) begin
                dstore[c] = ccsnoopaddr[c][wordSelBit] ? dirtyHi[c] : dirtyLo[c];
            end
        end
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic wordT fillWord(addrT a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h5A5A_0F0F;
    endfunction

    function automatic wordT readRam(addrT a);
        return ramMem.exists(a) ? ramMem[a] : fillWord(a);
    endfunction

    // expected word from the shadow copy of memory
    function automatic wordT expectWord(addrT a);
        return shadow.exists(a) ? shadow[a] : fillWord(a);
    endfunction

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        assert (expected == actual)
        else begin
            abortRun($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // RAM model with 0 to 3 busy cycles and one ACCESS cycle per word
    always @(negedge CLK) begin
        if (!(ramREN || ramWEN)) begin
            ramstate = FREE;
        end else begin
            if (ramstate == ACCESS || ramstate == FREE) begin
                busyLeft = int'(nextRand() % 4);
            end else begin
                busyLeft = busyLeft - 1;
            end
            ramstate = (busyLeft == 0) ? ACCESS : BUSY;
            ramload  = readRam(ramaddr);
        end
    end

    always @(posedge CLK) begin
        if (ramWEN && ramstate == ACCESS) begin
            ramMem[ramaddr] = ramstore;
        end
        for (int c = 0; c < coreCount; c++) begin
            if (ccinv[c]) begin
                invCount[c]++;
            end
        end
    end

    // snoop responders answer once per snoop after a random delay
    always @(negedge CLK) begin
        for (int c = 0; c < coreCount; c++) begin
            if (respTrans[c]) begin
                respTrans[c] = 1'b0;
                respWrite[c] = 1'b0;
            end else if (!ccwait[c]) begin
                answered[c]  = 1'b0;
                respDelay[c] = int'(nextRand() % 3);
            end else if (!answered[c]) begin
                if (respDelay[c] == 0) begin
                    respTrans[c] = 1'b1;
                    respWrite[c] = dirtyMode[c];
                    answered[c]  = 1'b1;
                end else begin
                    respDelay[c]--;
                end
            end
        end
    end

    task automatic fetchInstr(input int core, input addrT addr, output wordT word);
        int cycles;
        cycles = 0;
        @(negedge CLK);
        iaddr[core] = addr;
        iREN[core]  = 1'b1;
        #2;
        while (iwait[core]) begin
            cycles++;
            if (cycles > timeoutCycles) begin
                abortRun($sformatf("fetch by core %0d never completed", core));
            end
            @(negedge CLK);
            #2;
        end
        word = iload[core];
        @(negedge CLK);
        iREN[core] = 1'b0;
    endtask

    task automatic readBlock(input int core, input addrT addr, input logic own,
                             output wordT w0, output wordT w1);
        int   n;
        int   cycles;
        wordT got [2];
        n      = 0;
        cycles = 0;
        @(negedge CLK);
        daddr[core]  = addr;
        dREN[core]   = 1'b1;
        intent[core] = own;
        while (n < 2) begin
            #2;
            if (!dwait[core]) begin
                got[n] = dload[core];
                n++;
            end else begin
                cycles++;
                if (cycles > timeoutCycles) begin
                    abortRun($sformatf("block read by core %0d never completed", core));
                end
            end
            @(negedge CLK);
        end
        dREN[core]   = 1'b0;
        intent[core] = 1'b0;
        w0 = got[0];
        w1 = got[1];
    endtask

    task automatic writeBlock(input int core, input addrT addr, input wordT w0, input wordT w1);
        int n;
        int cycles;
        n      = 0;
        cycles = 0;
        @(negedge CLK);
        daddr[core] = addr;
        dWEN[core]  = 1'b1;
        while (n < 2) begin
            storeData[core] = (n == 0) ? w0 : w1;
            #2;
            if (!dwait[core]) begin
                n++;
            end else begin
                cycles++;
                if (cycles > timeoutCycles) begin
                    abortRun($sformatf("writeback by core %0d never completed", core));
                end
            end
            @(negedge CLK);
        end
        dWEN[core] = 1'b0;
    endtask

    initial begin
        wordT w0;
        wordT w1;
        wordT fw;
        int   invBefore;
        time  fetchAt;
        time  readAt;

        rngState  = 32'h6f75_6407;
        nRST      = 1'b0;
        iREN      = '0;
        dREN      = '0;
        dWEN      = '0;
        iaddr     = '0;
        daddr     = '0;
        intent    = '0;
        respTrans = '0;
        respWrite = '0;
        dirtyMode = '0;
        answered  = '0;
        storeData = '0;
        dirtyLo   = '0;
        dirtyHi   = '0;
        ramstate  = FREE;
        ramload   = '0;
        busyLeft  = 0;
        for (int c = 0; c < coreCount; c++) begin
            respDelay[c] = 0;
            invCount[c]  = 0;
        end
        repeat (16) @(negedge CLK);
        nRST = 1'b1;
        repeat (2) @(negedge CLK);

        // instruction fetch from each core
        fetchInstr(0, 32'h0000_0100, fw);
        checkWord("fetch core 0", expectWord(32'h0000_0100), fw);
        fetchInstr(1, 32'h0000_0204, fw);
        checkWord("fetch core 1", expectWord(32'h0000_0204), fw);

        // clean miss with bit 2 set so the second word sits below the first
        invBefore = invCount[1];
        readBlock(0, 32'h0000_050C, 1'b0, w0, w1);
        checkWord("clean read word 0", expectWord(32'h0000_050C), w0);
        checkWord("clean read word 1", expectWord(32'h0000_0508), w1);
        assert (invCount[1] == invBefore)
        else abortRun("plain read invalidated the other cache");

        // core 1 holds the block Modified
        dirtyMode[1] = 1'b1;
        dirtyLo[1]   = 32'hC0DE_0600;
        dirtyHi[1]   = 32'hC0DE_0604;
        readBlock(0, 32'h0000_0600, 1'b0, w0, w1);
        dirtyMode[1] = 1'b0;
        shadow[32'h0000_0600] = dirtyLo[1];
        shadow[32'h0000_0604] = dirtyHi[1];
        checkWord("dirty snoop ram word 0", expectWord(32'h0000_0600), readRam(32'h0000_0600));
        checkWord("dirty snoop ram word 1", expectWord(32'h0000_0604), readRam(32'h0000_0604));
        checkWord("dirty snoop load 0", expectWord(32'h0000_0600), w0);
        checkWord("dirty snoop load 1", expectWord(32'h0000_0604), w1);

        // read for ownership
        invBefore = invCount[0];
        readBlock(1, 32'h0000_0700, 1'b1, w0, w1);
        checkWord("ownership read word 0", expectWord(32'h0000_0700), w0);
        checkWord("ownership read word 1", expectWord(32'h0000_0704), w1);
        assert (invCount[0] == invBefore + 1)
        else abortRun("ownership read did not invalidate core 0 exactly once");

        // writeback then read the block back
        writeBlock(1, 32'h0000_0808, 32'hFEED_0808, 32'hFEED_080C);
        shadow[32'h0000_0808] = 32'hFEED_0808;
        shadow[32'h0000_080C] = 32'hFEED_080C;
        readBlock(0, 32'h0000_0808, 1'b0, w0, w1);
        checkWord("writeback word 0", expectWord(32'h0000_0808), w0);
        checkWord("writeback word 1", expectWord(32'h0000_080C), w1);

        // data request of core 1 wins over the fetch of core 0
        fetchAt = 0;
        readAt  = 0;
        fork
            begin
                fetchInstr(0, 32'h0000_0900, fw);
                fetchAt = $time;
            end
            begin
                readBlock(1, 32'h0000_0A00, 1'b0, w0, w1);
                readAt = $time;
            end
        join
        checkWord("priority fetch", expectWord(32'h0000_0900), fw);
        checkWord("priority read word 1", expectWord(32'h0000_0A04), w1);
        assert (fetchAt > readAt)
        else abortRun("fetch of core 0 finished before the read of core 1");

        $display("Everything OK");
        $finish;
    end

endmodule

/* busCoherence.f */
logic/memTypesPkg.sv
logic/coherencePkg.sv
logic/requestArbiter.sv
logic/coherenceFsm.sv
logic/busDatapath.sv
logic/busController.sv
testbench/tbClock.sv
testbench/busController_assertions.sv
testbench/busControllerTb.sv

/* run.sh */
#!/bin/sh
# Build and run the bus controller testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f busCoherence.f \
    --top-module busControllerTb \
    -o simBusController

./obj_dir/simBusController > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0
